// File: verilog.f
rtl/ddr4_bridge_pkg.sv
rtl/req_fifo.sv
rtl/app_cmd_arbiter.sv
rtl/read_sequencer.sv
rtl/read_buffer.sv
rtl/ddr4_mem_app_bridge.sv
testbench/ddr4_app_model.sv
testbench/bridge_sva.sv
testbench/tb_ddr4_mem_app_bridge.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps -f verilog.f \
    --top-module tb_ddr4_mem_app_bridge -o tb_sim &&
./obj_dir/tb_sim | grep "TB PASSED" && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: testbench/tb_ddr4_mem_app_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ddr4_mem_app_bridge;

    import ddr4_bridge_pkg::*;

    localparam int          CLK_NS       = 10;
    localparam int          RESET_CYCLES = 16;
    localparam int          MEM_BYTES    = 256 * 64;
    localparam logic [31:0] SEED         = 32'h60c658ec;
    // six tests of at most 64 lines at about five cycles per line
    localparam int          TESTS        = 6;
    localparam int          MAX_LINES    = 64;
    localparam int          WATCHDOG_NS  = (TESTS * MAX_LINES * 5 + 80) * CLK_NS;

    logic      mem_clk = 1'b0;
    logic      mem_reset_n;
    logic      mem_en;
    logic      mem_req;
    mem_bsel_t mem_wben;
    mem_addr_t mem_addr;
    mem_data_t mem_wdata;
    mem_data_t mem_rdata;
    logic      mem_rdata_avail;
    logic      mem_wstall;
    logic      mem_rstall;
    logic      mem_access;
    rd_state_e status;
    logic      busy;

    app_addr_t app_addr;
    app_cmd_e  app_cmd;
    logic      app_en;
    app_data_t wdf_data;
    logic      wdf_end;
    app_mask_t wdf_mask;
    logic      wdf_wren;
    app_data_t rd_data;
    logic      rd_end;
    logic      rd_valid;
    logic      app_rdy;
    logic      wdf_rdy;

    // byte image of what DRAM should hold
    logic [7:0]  shadow [MEM_BYTES];
    logic [31:0] writes_sent    = '0;
    logic [31:0] writes_done    = '0;
    logic [31:0] lines_returned = '0;
    logic        fetch_pend     = 1'b0;
    mem_addr_t   fetch_addr_q;
    mem_data_t   expected_word;
    int          errors = 0;
    int          checks = 0;
    int          seed   = SEED;

    always #(CLK_NS / 2) mem_clk = ~mem_clk;

    ddr4_mem_app_bridge #(
        .FIFO_DEPTH_LOG2 (2),
        .BUF_ADDR_WIDTH  (6)
    ) u_dut (
        .mem_clk_i                (mem_clk),
        .mem_reset_n_i            (mem_reset_n),
        .mem_en_i                 (mem_en),
        .mem_req_i                (mem_req),
        .mem_wben_i               (mem_wben),
        .mem_addr_i               (mem_addr),
        .mem_wdata_i              (mem_wdata),
        .mem_rdata_o              (mem_rdata),
        .mem_rdata_avail_o        (mem_rdata_avail),
        .mem_wstall_o             (mem_wstall),
        .mem_rstall_o             (mem_rstall),
        .mem_access_i             (mem_access),
        .ddr4_app_addr_o          (app_addr),
        .ddr4_app_cmd_o           (app_cmd),
        .ddr4_app_en_o            (app_en),
        .ddr4_app_wdf_data_o      (wdf_data),
        .ddr4_app_wdf_end_o       (wdf_end),
        .ddr4_app_wdf_mask_o      (wdf_mask),
        .ddr4_app_wdf_wren_o      (wdf_wren),
        .ddr4_app_rd_data_i       (rd_data),
        .ddr4_app_rd_data_end_i   (rd_end),
        .ddr4_app_rd_data_valid_i (rd_valid),
        .ddr4_app_rdy_i           (app_rdy),
        .ddr4_app_wdf_rdy_i       (wdf_rdy),
        .ddr4_status_o            (status)
    );

    ddr4_app_model #(
        .LINES   (256),
        .LATENCY (8),
        .SEED    (SEED)
    ) u_model (
        .mem_clk_i           (mem_clk),
        .busy_i              (busy),
        .app_addr_i          (app_addr),
        .app_cmd_i           (app_cmd),
        .app_en_i            (app_en),
        .app_wdf_data_i      (wdf_data),
        .app_wdf_end_i       (wdf_end),
        .app_wdf_mask_i      (wdf_mask),
        .app_wdf_wren_i      (wdf_wren),
        .app_rd_data_o       (rd_data),
        .app_rd_data_end_o   (rd_end),
        .app_rd_data_valid_o (rd_valid),
        .app_rdy_o           (app_rdy),
        .app_wdf_rdy_o       (wdf_rdy)
    );

    // ------------------------------
    // reference model
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ 8'ha5;
    endfunction

    // 16-byte word holding addr, taken from the shadow image
    function automatic mem_data_t ref_word(input mem_addr_t addr);
        mem_data_t   w;
        logic [13:0] idx;
        for (int b = 0; b < 16; b++) begin
            idx = 14'({addr[31:4], 4'b0000} + 32'(b));
            w[b*8 +: 8] = shadow[idx];
        end
        return w;
    endfunction

    function automatic mem_data_t rand_word();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // ------------------------------
    // tile port tasks start right after a falling edge
    task automatic write_word(input mem_addr_t addr, input mem_data_t data,
                              input mem_bsel_t bsel);
        logic [13:0] idx;
        while (mem_wstall) @(negedge mem_clk);
        mem_en    = 1'b1;
        mem_wben  = bsel;
        mem_addr  = addr;
        mem_wdata = data;
        for (int b = 0; b < 16; b++) begin
            idx = 14'({addr[31:4], 4'b0000} + 32'(b));
            if (bsel[b]) shadow[idx] = data[b*8 +: 8];
        end
        writes_sent = writes_sent + 32'd1;
        @(negedge mem_clk);
        mem_en   = 1'b0;
        mem_wben = '0;
    endtask

    task automatic drain_writes();
        while (writes_done != writes_sent) @(negedge mem_clk);
    endtask

    task automatic fetch_word(input mem_addr_t addr);
        mem_en   = 1'b1;
        mem_wben = '0;
        mem_addr = addr;
        @(negedge mem_clk);
        mem_en = 1'b0;
    endtask

    task automatic read_burst(input mem_addr_t addr, input req_size_t size);
        logic [31:0] nlines;
        logic [31:0] lines_start;
        mem_addr_t   a;
        drain_writes();
        while (mem_rstall) @(negedge mem_clk);
        // lines touched, counting the offset within the first line
        nlines      = (size + {26'd0, addr[5:0]} + 32'd63) >> 6;
        lines_start = lines_returned;
        mem_req     = 1'b1;
        mem_addr    = addr;
        mem_wdata   = {96'd0, size};
        mem_access  = 1'b1;
        @(negedge mem_clk);
        mem_req = 1'b0;
        while (lines_returned - lines_start < nlines) @(negedge mem_clk);
        for (a = {addr[31:4], 4'b0000}; a < addr + size; a = a + 32'd16) begin
            fetch_word(a);
        end
        assert (status == RD_DRAIN && mem_rdata_avail) else begin
            errors = errors + 1;
            $display("[ERROR] %0t read FSM in state %0d with avail %b, not draining",
                     $time, status, mem_rdata_avail);
        end
        mem_access = 1'b0;
        while (status != RD_IDLE) @(negedge mem_clk);
    endtask

    // ------------------------------
    // DDR4 side counters and fetch capture
    always @(posedge mem_clk) begin
        if (app_en && app_rdy && wdf_rdy && app_cmd == APP_CMD_WRITE) begin
            writes_done <= writes_done + 32'd1;
        end
        if (rd_valid && rd_end) begin
            lines_returned <= lines_returned + 32'd1;
        end
        fetch_pend   <= mem_reset_n && mem_en && (mem_wben == '0);
        fetch_addr_q <= mem_addr;
    end

    // rdata is one cycle behind the fetch strobe
    always @(negedge mem_clk) begin
        if (fetch_pend) begin
            expected_word = ref_word(fetch_addr_q);
            checks        = checks + 1;
            assert (mem_rdata === expected_word) else begin
                errors = errors + 1;
                $display("[ERROR] %0t fetch at %h: got %h, expected %h",
                         $time, fetch_addr_q, mem_rdata, expected_word);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the bridge hung", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    // ------------------------------
    // test sequence
    initial begin
        mem_reset_n = 1'b1;
        mem_en      = 1'b0;
        mem_req     = 1'b0;
        mem_wben    = '0;
        mem_addr    = '0;
        mem_wdata   = '0;
        mem_access  = 1'b0;
        busy        = 1'b0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            shadow[14'(a)] = fill_byte(32'(a));
        end
        #1 mem_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge mem_clk);
        @(negedge mem_clk);
        mem_reset_n = 1'b1;
        @(negedge mem_clk);

        assert (status == RD_IDLE && !mem_wstall && !mem_rstall && !mem_rdata_avail)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t reset state: status %0d wstall %b rstall %b avail %b",
                     $time, status, mem_wstall, mem_rstall, mem_rdata_avail);
        end

        // all four lanes of one line
        for (int i = 0; i < 4; i++) begin
            write_word(32'h100 + 32'(i * 16), rand_word(), 16'hffff);
        end
        read_burst(32'h100, 32'd64);

        // partial byte enables, then a short unaligned read
        write_word(32'h100, rand_word(), 16'h00f0);
        write_word(32'h130, rand_word(), 16'h8001);
        write_word(32'h150, rand_word(), 16'h0ff0);
        read_burst(32'h100, 32'd64);
        read_burst(32'h150, 32'd16);

        // six lines starting 0x30 into a line
        read_burst(32'h430, 32'd300);

        // back-to-back writes against random readies
        busy = 1'b1;
        for (int i = 0; i < 8; i++) begin
            write_word(32'h800 + 32'(i * 16), rand_word(), 16'hffff);
        end
        read_burst(32'h800, 32'd128);
        busy = 1'b0;

        @(negedge mem_clk);
        $display("fetch checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/bridge_sva.sv
`timescale 1ns/100ps
`default_nettype none

module bridge_sva (
    input  wire                              mem_clk_i,
    input  wire                              mem_reset_n_i,
    input  wire                              app_en_i,
    input  wire  ddr4_bridge_pkg::app_cmd_e  app_cmd_i,
    input  wire  ddr4_bridge_pkg::app_addr_t app_addr_i,
    input  wire                              wdf_wren_i,
    input  wire                              wdf_end_i
);

    import ddr4_bridge_pkg::*;

    // write data goes out with its command
    write_data_with_cmd: assert property (@(posedge mem_clk_i) disable iff (!mem_reset_n_i)
        (app_en_i && app_cmd_i == APP_CMD_WRITE) |-> (wdf_wren_i && wdf_end_i))
        else $error("write command without wdf_wren and wdf_end");

    line_aligned_addr: assert property (@(posedge mem_clk_i) disable iff (!mem_reset_n_i)
        app_en_i |-> (app_addr_i[2:0] == 3'b000))
        else $error("app_addr low bits not zero");

    no_cmd_in_reset: assert property (@(posedge mem_clk_i)
        !mem_reset_n_i |-> !app_en_i)
        else $error("app_en high during reset");

endmodule

bind ddr4_mem_app_bridge bridge_sva u_sva (
    .mem_clk_i     (mem_clk_i),
    .mem_reset_n_i (mem_reset_n_i),
    .app_en_i      (ddr4_app_en_o),
    .app_cmd_i     (ddr4_app_cmd_o),
    .app_addr_i    (ddr4_app_addr_o),
    .wdf_wren_i    (ddr4_app_wdf_wren_o),
    .wdf_end_i     (ddr4_app_wdf_end_o)
);

`default_nettype wire

// File: testbench/ddr4_app_model.sv
`timescale 1ns/100ps
`default_nettype none

module ddr4_app_model #(
    parameter int          LINES   = 256,
    parameter int          LATENCY = 8,
    parameter logic [31:0] SEED    = 32'h1
) (
    input  wire                              mem_clk_i,
    // randomize both readies while high
    input  wire                              busy_i,
    input  wire  ddr4_bridge_pkg::app_addr_t app_addr_i,
    input  wire  ddr4_bridge_pkg::app_cmd_e  app_cmd_i,
    input  wire                              app_en_i,
    input  wire  ddr4_bridge_pkg::app_data_t app_wdf_data_i,
    input  wire                              app_wdf_end_i,
    input  wire  ddr4_bridge_pkg::app_mask_t app_wdf_mask_i,
    input  wire                              app_wdf_wren_i,
    output ddr4_bridge_pkg::app_data_t       app_rd_data_o,
    output logic                             app_rd_data_end_o,
    output logic                             app_rd_data_valid_o,
    output logic                             app_rdy_o,
    output logic                             app_wdf_rdy_o
);

    import ddr4_bridge_pkg::*;

    localparam int LINE_W = $clog2(LINES);

    app_data_t                 mem [LINES];
    logic [LATENCY-1:0]        pipe_vld;
    logic [LATENCY-1:0][511:0] pipe_data;
    logic [LINE_W-1:0]         line;
    logic                      rd_go;
    logic                      wr_go;
    logic                      busy_q;
    logic [31:0]               rnd;
    logic [31:0]               byte_addr;
    int                        seed = SEED;

    // app_addr[2:0] carry no line information
    assign line  = app_addr_i[3 +: LINE_W];
    assign rd_go = app_en_i && app_rdy_o && (app_cmd_i == APP_CMD_READ);
    assign wr_go = app_en_i && app_rdy_o && app_wdf_rdy_o && app_wdf_wren_i &&
                   app_wdf_end_i && (app_cmd_i == APP_CMD_WRITE);

    // memory starts with a pattern of the byte address
    initial begin
        for (int l = 0; l < LINES; l++) begin
            for (int b = 0; b < 64; b++) begin
                byte_addr = 32'(l * 64 + b);
                mem[LINE_W'(l)][b*8 +: 8] <= byte_addr[7:0] ^ byte_addr[15:8] ^ 8'ha5;
            end
        end
        pipe_vld            <= '0;
        pipe_data           <= '0;
        busy_q              <= 1'b0;
        app_rdy_o           <= 1'b0;
        app_wdf_rdy_o       <= 1'b0;
        app_rd_data_o       <= '0;
        app_rd_data_end_o   <= 1'b0;
        app_rd_data_valid_o <= 1'b0;
    end

    // ------------------------------
    // command side and read latency pipe
    always @(posedge mem_clk_i) begin
        busy_q    <= busy_i;
        pipe_vld  <= {pipe_vld[LATENCY-2:0], rd_go};
        pipe_data <= {pipe_data[LATENCY-2:0], mem[line]};
        if (wr_go) begin
            for (int b = 0; b < 64; b++) begin
                if (!app_wdf_mask_i[b]) begin
                    mem[line][b*8 +: 8] <= app_wdf_data_i[b*8 +: 8];
                end
            end
        end
    end

    // outputs change on the falling edge
    always @(negedge mem_clk_i) begin
        rnd = $random(seed);
        app_rdy_o           <= busy_q ? rnd[0] : 1'b1;
        app_wdf_rdy_o       <= busy_q ? rnd[1] : 1'b1;
        app_rd_data_valid_o <= pipe_vld[LATENCY-1];
        app_rd_data_end_o   <= pipe_vld[LATENCY-1];
        app_rd_data_o       <= pipe_data[LATENCY-1];
    end

endmodule

`default_nettype wire

// File: rtl/ddr4_mem_app_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module ddr4_mem_app_bridge #(
    parameter int FIFO_DEPTH_LOG2 = 2,
    parameter int BUF_ADDR_WIDTH  = 6
) (
    input  wire                              mem_clk_i,
    input  wire                              mem_reset_n_i,

    // tile memory port
    input  wire                              mem_en_i,
    input  wire                              mem_req_i,
    input  wire  ddr4_bridge_pkg::mem_bsel_t mem_wben_i,
    input  wire  ddr4_bridge_pkg::mem_addr_t mem_addr_i,
    input  wire  ddr4_bridge_pkg::mem_data_t mem_wdata_i,
    output ddr4_bridge_pkg::mem_data_t       mem_rdata_o,
    output logic                             mem_rdata_avail_o,
    output logic                             mem_wstall_o,
    output logic                             mem_rstall_o,
    input  wire                              mem_access_i,

    // DDR4 user interface
    output ddr4_bridge_pkg::app_addr_t       ddr4_app_addr_o,
    output ddr4_bridge_pkg::app_cmd_e        ddr4_app_cmd_o,
    output logic                             ddr4_app_en_o,
    output ddr4_bridge_pkg::app_data_t       ddr4_app_wdf_data_o,
    output logic                             ddr4_app_wdf_end_o,
    output ddr4_bridge_pkg::app_mask_t       ddr4_app_wdf_mask_o,
    output logic                             ddr4_app_wdf_wren_o,
    input  wire  ddr4_bridge_pkg::app_data_t ddr4_app_rd_data_i,
    input  wire                              ddr4_app_rd_data_end_i,
    input  wire                              ddr4_app_rd_data_valid_i,
    input  wire                              ddr4_app_rdy_i,
    input  wire                              ddr4_app_wdf_rdy_i,

    output ddr4_bridge_pkg::rd_state_e       ddr4_status_o
);

    import ddr4_bridge_pkg::*;

    wr_req_t  wr_head;
    logic     wr_empty;
    logic     wr_pop;
    rd_req_t  rd_head;
    logic     rd_empty;
    logic     rd_pop;
    app_cmd_t rd_cmd;
    logic     rd_issuing;
    logic     rd_cmd_accept;
    logic     burst_done;

    // ------------------------------
    // request FIFOs
    req_fifo #(
        .WIDTH           ($bits(wr_req_t)),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_wr_fifo (
        .mem_clk_i     (mem_clk_i),
        .mem_reset_n_i (mem_reset_n_i),
        .push_i        (mem_en_i && (|mem_wben_i)),
        .pop_i         (wr_pop),
        .wdata_i       ({mem_wben_i, mem_addr_i, mem_wdata_i}),
        .rdata_o       (wr_head),
        .full_o        (mem_wstall_o),
        .empty_o       (wr_empty)
    );

    // read request carries the byte count in the low data word
    req_fifo #(
        .WIDTH           ($bits(rd_req_t)),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_rd_fifo (
        .mem_clk_i     (mem_clk_i),
        .mem_reset_n_i (mem_reset_n_i),
        .push_i        (mem_req_i && (mem_wben_i == '0)),
        .pop_i         (rd_pop),
        .wdata_i       ({mem_addr_i, mem_wdata_i[31:0]}),
        .rdata_o       (rd_head),
        .full_o        (mem_rstall_o),
        .empty_o       (rd_empty)
    );

    // ------------------------------
    // command path
    app_cmd_arbiter u_arbiter (
        .wr_head_i       (wr_head),
        .wr_empty_i      (wr_empty),
        .rd_cmd_i        (rd_cmd),
        .rd_issuing_i    (rd_issuing),
        .app_rdy_i       (ddr4_app_rdy_i),
        .app_wdf_rdy_i   (ddr4_app_wdf_rdy_i),
        .wr_pop_o        (wr_pop),
        .rd_cmd_accept_o (rd_cmd_accept),
        .app_addr_o      (ddr4_app_addr_o),
        .app_cmd_o       (ddr4_app_cmd_o),
        .app_en_o        (ddr4_app_en_o),
        .app_wdf_data_o  (ddr4_app_wdf_data_o),
        .app_wdf_mask_o  (ddr4_app_wdf_mask_o),
        .app_wdf_end_o   (ddr4_app_wdf_end_o),
        .app_wdf_wren_o  (ddr4_app_wdf_wren_o)
    );

    read_sequencer u_sequencer (
        .mem_clk_i       (mem_clk_i),
        .mem_reset_n_i   (mem_reset_n_i),
        .rd_head_i       (rd_head),
        .rd_empty_i      (rd_empty),
        .rd_cmd_accept_i (rd_cmd_accept),
        .data_avail_i    (mem_rdata_avail_o),
        .rd_pop_o        (rd_pop),
        .rd_cmd_o        (rd_cmd),
        .rd_issuing_o    (rd_issuing),
        .burst_done_o    (burst_done),
        .state_o         (ddr4_status_o)
    );

    // ------------------------------
    // returned lines and fetches
    read_buffer #(
        .BUF_ADDR_WIDTH (BUF_ADDR_WIDTH)
    ) u_read_buffer (
        .mem_clk_i     (mem_clk_i),
        .mem_reset_n_i (mem_reset_n_i),
        .rd_valid_i    (ddr4_app_rd_data_valid_i),
        .rd_end_i      (ddr4_app_rd_data_end_i),
        .rd_data_i     (ddr4_app_rd_data_i),
        .fetch_i       (mem_en_i && (mem_wben_i == '0)),
        .fetch_addr_i  (mem_addr_i),
        .start_addr_i  (rd_head.addr),
        .mem_access_i  (mem_access_i),
        .burst_done_i  (burst_done),
        .rdata_o       (mem_rdata_o),
        .data_avail_o  (mem_rdata_avail_o)
    );

endmodule

`default_nettype wire

// File: rtl/read_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module read_buffer #(
    parameter int BUF_ADDR_WIDTH = 6
) (
    input  wire                             mem_clk_i,
    input  wire                             mem_reset_n_i,
    input  wire                             rd_valid_i,
    input  wire                             rd_end_i,
    input  wire  ddr4_bridge_pkg::app_data_t rd_data_i,
    input  wire                             fetch_i,
    input  wire  ddr4_bridge_pkg::mem_addr_t fetch_addr_i,
    input  wire  ddr4_bridge_pkg::mem_addr_t start_addr_i,
    input  wire                             mem_access_i,
    input  wire                             burst_done_i,
    output ddr4_bridge_pkg::mem_data_t      rdata_o,
    output logic                            data_avail_o
);

    import ddr4_bridge_pkg::*;

    localparam int LANE_W     = $bits(mem_data_t);
    localparam int LANE_SEL_W = $clog2($bits(app_data_t) / LANE_W);

    app_data_t lines [2 ** BUF_ADDR_WIDTH];

    // written-line count needs one bit more to reach the full depth
    logic [BUF_ADDR_WIDTH:0]   wr_cnt;
    logic [BUF_ADDR_WIDTH-1:0] rd_idx;
    logic                      line_we;
    mem_addr_t                 line_diff;
    app_data_t                 line_q;
    logic [LANE_SEL_W-1:0]     lane_q;

    assign line_we   = rd_valid_i && rd_end_i;
    assign line_diff = (fetch_addr_i >> LINE_SHIFT) - (start_addr_i >> LINE_SHIFT);

    // ------------------------------
    // line memory with one cycle of read latency
    always_ff @(posedge mem_clk_i) begin
        if (line_we) begin
            lines[wr_cnt[BUF_ADDR_WIDTH-1:0]] <= rd_data_i;
        end
        if (fetch_i) begin
            line_q <= lines[line_diff[BUF_ADDR_WIDTH-1:0]];
            lane_q <= fetch_addr_i[LINE_SHIFT-1 -: LANE_SEL_W];
        end
    end

    // ------------------------------
    // buffer pointers
    always_ff @(posedge mem_clk_i or negedge mem_reset_n_i) begin
        if (!mem_reset_n_i) begin
            wr_cnt <= '0;
            rd_idx <= '0;
        end else if (burst_done_i) begin
            wr_cnt <= '0;
            rd_idx <= '0;
        end else begin
            if (line_we) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (fetch_i) begin
                rd_idx <= line_diff[BUF_ADDR_WIDTH-1:0];
            end
        end
    end

    assign data_avail_o = (wr_cnt > {1'b0, rd_idx}) && mem_access_i;
    assign rdata_o      = line_q[lane_q*LANE_W +: LANE_W];

endmodule

`default_nettype wire

// File: rtl/read_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module read_sequencer (
    input  wire                             mem_clk_i,
    input  wire                             mem_reset_n_i,
    input  wire  ddr4_bridge_pkg::rd_req_t  rd_head_i,
    input  wire                             rd_empty_i,
    input  wire                             rd_cmd_accept_i,
    input  wire                             data_avail_i,
    output logic                            rd_pop_o,
    output ddr4_bridge_pkg::app_cmd_t       rd_cmd_o,
    output logic                            rd_issuing_o,
    output logic                            burst_done_o,
    output ddr4_bridge_pkg::rd_state_e      state_o
);

    import ddr4_bridge_pkg::*;

    localparam int LINE_BYTES = 1 << LINE_SHIFT;
    localparam int APP_LINE_W = $bits(app_addr_t) - 3;

    rd_state_e state_q;
    rd_state_e state_d;
    mem_addr_t line_addr_q;
    mem_addr_t line_addr_d;
    req_size_t rem_bytes_q;
    req_size_t rem_bytes_d;
    req_size_t burst_bytes;

    // size plus the start offset in the first line, so that the
    // line count is this value rounded up to whole lines
    assign burst_bytes = rd_head_i.size + req_size_t'(rd_head_i.addr[LINE_SHIFT-1:0]);

    // ------------------------------
    // next state
    always_comb begin
        state_d      = state_q;
        line_addr_d  = line_addr_q;
        rem_bytes_d  = rem_bytes_q;
        rd_pop_o     = 1'b0;
        burst_done_o = 1'b0;

        case (state_q)
            RD_IDLE: begin
                if (!rd_empty_i) begin
                    line_addr_d = rd_head_i.addr & ~mem_addr_t'(LINE_BYTES - 1);
                    rem_bytes_d = burst_bytes;
                    state_d     = RD_ISSUE;
                end
            end

            // one line read per accepted command
            RD_ISSUE: begin
                if (rd_cmd_accept_i) begin
                    line_addr_d = line_addr_q + mem_addr_t'(LINE_BYTES);
                    if (rem_bytes_q > req_size_t'(LINE_BYTES)) begin
                        rem_bytes_d = rem_bytes_q - req_size_t'(LINE_BYTES);
                    end else begin
                        rem_bytes_d = '0;
                        state_d     = RD_WAIT;
                    end
                end
            end

            // first line has not arrived yet
            RD_WAIT: begin
                if (data_avail_i) begin
                    state_d = RD_DRAIN;
                end
            end

            // requester fetches until it drops mem_access
            RD_DRAIN: begin
                if (!data_avail_i) begin
                    rd_pop_o = 1'b1;
                    state_d  = RD_FINISH;
                end
            end

            RD_FINISH: begin
                burst_done_o = 1'b1;
                state_d      = RD_IDLE;
            end

            default: begin
                state_d = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge mem_clk_i or negedge mem_reset_n_i) begin
        if (!mem_reset_n_i) begin
            state_q     <= RD_IDLE;
            line_addr_q <= '0;
            rem_bytes_q <= '0;
        end else begin
            state_q     <= state_d;
            line_addr_q <= line_addr_d;
            rem_bytes_q <= rem_bytes_d;
        end
    end

    assign rd_issuing_o = (state_q == RD_ISSUE);
    assign state_o      = state_q;
    assign rd_cmd_o     = '{
        en:   rd_issuing_o,
        cmd:  APP_CMD_READ,
        addr: {line_addr_q[LINE_SHIFT +: APP_LINE_W], 3'b000}
    };

endmodule

`default_nettype wire

// File: rtl/app_cmd_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module app_cmd_arbiter (
    input  wire  ddr4_bridge_pkg::wr_req_t  wr_head_i,
    input  wire                             wr_empty_i,
    input  wire  ddr4_bridge_pkg::app_cmd_t rd_cmd_i,
    input  wire                             rd_issuing_i,
    input  wire                             app_rdy_i,
    input  wire                             app_wdf_rdy_i,
    output logic                            wr_pop_o,
    output logic                            rd_cmd_accept_o,
    output ddr4_bridge_pkg::app_addr_t      app_addr_o,
    output ddr4_bridge_pkg::app_cmd_e       app_cmd_o,
    output logic                            app_en_o,
    output ddr4_bridge_pkg::app_data_t      app_wdf_data_o,
    output ddr4_bridge_pkg::app_mask_t      app_wdf_mask_o,
    output logic                            app_wdf_end_o,
    output logic                            app_wdf_wren_o
);

    import ddr4_bridge_pkg::*;

    localparam int LANE_W     = $bits(mem_data_t);
    localparam int LANE_BYTES = $bits(mem_bsel_t);
    localparam int LANE_SEL_W = $clog2($bits(app_data_t) / LANE_W);
    localparam int APP_LINE_W = $bits(app_addr_t) - 3;

    logic [LANE_SEL_W-1:0] lane;
    logic                  wr_go;

    // 128-bit lane within the 64-byte line
    assign lane = wr_head_i.addr[LINE_SHIFT-1 -: LANE_SEL_W];

    // writes only go out while no read burst owns the command bus
    assign wr_go           = !wr_empty_i && app_rdy_i && app_wdf_rdy_i && !rd_issuing_i;
    assign wr_pop_o        = wr_go;
    assign rd_cmd_accept_o = rd_issuing_i && rd_cmd_i.en && app_rdy_i;

    assign app_wdf_wren_o = wr_go;
    assign app_wdf_end_o  = wr_go;

    // ------------------------------
    // write data and mask placement
    always_comb begin
        app_wdf_data_o = '0;
        app_wdf_mask_o = '1;
        app_wdf_data_o[lane*LANE_W +: LANE_W]         = wr_head_i.data;
        app_wdf_mask_o[lane*LANE_BYTES +: LANE_BYTES] = ~wr_head_i.bsel;
    end

    // ------------------------------
    // command mux
    always_comb begin
        if (rd_issuing_i) begin
            app_en_o   = rd_cmd_accept_o;
            app_cmd_o  = rd_cmd_i.cmd;
            app_addr_o = rd_cmd_i.addr;
        end else begin
            app_en_o   = wr_go;
            app_cmd_o  = APP_CMD_WRITE;
            app_addr_o = {wr_head_i.addr[LINE_SHIFT +: APP_LINE_W], 3'b000};
        end
    end

endmodule

`default_nettype wire

// File: rtl/req_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module req_fifo #(
    parameter int WIDTH           = 8,
    parameter int FIFO_DEPTH_LOG2 = 2
) (
    input  wire               mem_clk_i,
    input  wire               mem_reset_n_i,
    input  wire               push_i,
    input  wire               pop_i,
    input  wire  [WIDTH-1:0]  wdata_i,
    output logic [WIDTH-1:0]  rdata_o,
    output logic              full_o,
    output logic              empty_o
);

    localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

    logic [WIDTH-1:0] entries [DEPTH];

    // one extra bit tells full from empty when the indices match
    logic [FIFO_DEPTH_LOG2:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2:0] rd_ptr;

    logic do_push;
    logic do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge mem_clk_i) begin
        if (do_push) begin
            entries[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= wdata_i;
        end
    end

    always_ff @(posedge mem_clk_i or negedge mem_reset_n_i) begin
        if (!mem_reset_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // head comes straight from the array
    assign rdata_o = entries[rd_ptr[FIFO_DEPTH_LOG2-1:0]];
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
                     (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);

endmodule

`default_nettype wire

// File: rtl/ddr4_bridge_pkg.sv
`default_nettype none

package ddr4_bridge_pkg;

    // ------------------------------
    // tile side
    typedef logic [31:0]  mem_addr_t;
    typedef logic [127:0] mem_data_t;
    typedef logic [15:0]  mem_bsel_t;
    typedef logic [31:0]  req_size_t;

    // ------------------------------
    // DDR4 user interface
    // app_addr[2:0] are ignored by the controller and always driven zero
    typedef logic [27:0]  app_addr_t;
    typedef logic [511:0] app_data_t;
    // a set mask bit keeps the byte unchanged
    typedef logic [63:0]  app_mask_t;

    // 64-byte lines
    localparam int LINE_SHIFT = 6;

    typedef enum logic [2:0] {
        APP_CMD_WRITE = 3'd0,
        APP_CMD_READ  = 3'd1
    } app_cmd_e;

    // ------------------------------
    // request FIFO entries
    typedef struct packed {
        mem_bsel_t bsel;
        mem_addr_t addr;
        mem_data_t data;
    } wr_req_t;

    typedef struct packed {
        mem_addr_t addr;
        req_size_t size;
    } rd_req_t;

    // read command from the sequencer
    typedef struct packed {
        logic      en;
        app_cmd_e  cmd;
        app_addr_t addr;
    } app_cmd_t;

    typedef enum logic [2:0] {
        RD_IDLE   = 3'd0,
        RD_ISSUE  = 3'd1,
        RD_WAIT   = 3'd2,
        RD_DRAIN  = 3'd3,
        RD_FINISH = 3'd4
    } rd_state_e;

endpackage

`default_nettype wire
